//--- hw/bp_pkg.sv
// ------------------------------------------------------------
// Branch prediction package
// Reset PC, table sizes, branch type codes, counter states
// and FSM encodings shared by the fetch predictor blocks
// ------------------------------------------------------------

package bp_pkg;

	// ------------------------------------------------------------
	// Fetch address
	// ------------------------------------------------------------

	// First fetch after reset
	localparam logic [31:0] RESET_PC = 32'h1C00_0000;

	// ------------------------------------------------------------
	// Table sizes
	// ------------------------------------------------------------

	// 64 entry BTB, index pc[8:3], tag pc[31:9]
	localparam int BTB_ADDR_WIDTH = 6;

	// 256 counter local PHT, index pc[10:3]
	localparam int LPHT_ADDR_WIDTH = 8;

	// Return stack entries
	localparam int RAS_DEPTH = 8;

	// ------------------------------------------------------------
	// Branch type codes, as stored in the BTB
	// ------------------------------------------------------------

	// PC relative, direction from PHT
	localparam logic [1:0] BR_PC_REL   = 2'd0;
	// Call, pushes return address
	localparam logic [1:0] BR_CALL     = 2'd1;
	// Return, target from RAS top
	localparam logic [1:0] BR_RETURN   = 2'd2;
	// Indirect jump, always taken
	localparam logic [1:0] BR_INDIRECT = 2'd3;

	// ------------------------------------------------------------
	// 2-bit saturating counter states
	// ------------------------------------------------------------

	localparam logic [1:0] CNT_SNT = 2'd0;
	localparam logic [1:0] CNT_WNT = 2'd1;
	localparam logic [1:0] CNT_WT  = 2'd2;
	localparam logic [1:0] CNT_ST  = 2'd3;

	// Upper counter bit means taken
	localparam int CNT_TAKEN_BIT = 1;

	// Value of every counter after reset
	localparam logic [1:0] CNT_RESET = CNT_WNT;

	// ------------------------------------------------------------
	// Fetch FSM
	// ------------------------------------------------------------

	// One refill cycle after reset or flush
	localparam logic ST_REFILL = 1'b0;
	localparam logic ST_READY  = 1'b1;

endpackage : bp_pkg

//--- hw/btb.sv
// ------------------------------------------------------------
// Branch target buffer
// Direct mapped, tagged, synchronous read by next PC
// Single training write port from the update channel
// ------------------------------------------------------------

`timescale 1ns/1ps

module btb #(
	parameter int ADDR_WIDTH = bp_pkg::BTB_ADDR_WIDTH
) (
	input  logic        clk,
	input  logic        rst_n,
	// Read side, next fetch PC
	input  logic [31:2] rpc_i,
	// Training write
	input  logic        we_i,
	input  logic [31:2] wpc_i,
	input  logic [31:2] bta_i,
	input  logic [1:0]  br_type_i,
	// Registered lookup result
	output logic        fsc_o,
	output logic        miss_o,
	output logic [31:2] bta_o,
	output logic [1:0]  br_type_o
);

	import bp_pkg::*;

	localparam int DEPTH   = 1 << ADDR_WIDTH;
	localparam int TAG_LSB = ADDR_WIDTH + 3;

	// Entry storage, valid bits are the only state under reset
	logic [DEPTH-1:0]   valid_q;
	logic [31:TAG_LSB]  tag_mem  [DEPTH];
	logic [31:2]        bta_mem  [DEPTH];
	logic [1:0]         type_mem [DEPTH];
	logic               fsc_mem  [DEPTH];

	// Index and tag of both ports
	logic [ADDR_WIDTH-1:0] rindex;
	logic [ADDR_WIDTH-1:0] windex;

	// Read stage registers
	logic               rd_valid_q;
	logic [31:TAG_LSB]  rd_tag_q;
	logic [31:TAG_LSB]  rd_req_tag_q;
	logic [31:2]        rd_bta_q;
	logic [1:0]         rd_type_q;
	logic               rd_fsc_q;
	logic               hit;

	assign rindex = rpc_i[TAG_LSB-1:3];
	assign windex = wpc_i[TAG_LSB-1:3];

	// ------------------------------------------------------------
	// Training write
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (we_i) begin
			valid_q[windex] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n && we_i) begin
			tag_mem[windex]  <= wpc_i[31:TAG_LSB];
			bta_mem[windex]  <= bta_i;
			type_mem[windex] <= br_type_i;
			// Branch sits in slot 0 of its fetch pair
			fsc_mem[windex]  <= ~wpc_i[2];
		end
	end

	// ------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------

	// Valid read under reset so a fresh run starts on a miss
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= valid_q[rindex];
		end
	end

	always_ff @(posedge clk) begin
		rd_tag_q     <= tag_mem[rindex];
		rd_req_tag_q <= rpc_i[31:TAG_LSB];
		rd_bta_q     <= bta_mem[rindex];
		rd_type_q    <= type_mem[rindex];
		rd_fsc_q     <= fsc_mem[rindex];
	end

	// Tag compare on the registered entry
	assign hit = rd_valid_q && (rd_tag_q == rd_req_tag_q);

	assign miss_o    = ~hit;
	assign bta_o     = rd_bta_q;
	assign fsc_o     = rd_fsc_q;
	// Miss reads as a plain fall-through branch
	assign br_type_o = hit ? rd_type_q : BR_PC_REL;

endmodule : btb

//--- hw/pht.sv
// ------------------------------------------------------------
// Local pattern history table
// 2-bit saturating counters, trained from the update channel
// ------------------------------------------------------------

`timescale 1ns/1ps

module pht #(
	parameter int ADDR_WIDTH = bp_pkg::LPHT_ADDR_WIDTH
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  we_i,
	input  logic                  taken_i,
	input  logic [1:0]            cnt_i,
	input  logic [ADDR_WIDTH-1:0] rindex_i,
	input  logic [ADDR_WIDTH-1:0] windex_i,
	output logic [1:0]            cnt_o
);

	import bp_pkg::*;

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [1:0] cnt_q [DEPTH];
	logic [1:0] cnt_next;

	// Step the predicted counter toward the resolved direction
	always_comb begin
		if (taken_i) begin
			cnt_next = (cnt_i == CNT_ST) ? CNT_ST : cnt_i + 2'd1;
		end else begin
			cnt_next = (cnt_i == CNT_SNT) ? CNT_SNT : cnt_i - 2'd1;
		end
	end

	// Counter array, all weakly not taken after reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				cnt_q[i] <= CNT_RESET;
			end
		end else if (we_i) begin
			cnt_q[windex_i] <= cnt_next;
		end
	end

	// Registered read
	always_ff @(posedge clk) begin
		cnt_o <= cnt_q[rindex_i];
	end

endmodule : pht

//--- hw/ras.sv
// ------------------------------------------------------------
// Return address stack
// Circular, push on call, pop on return, oldest overwritten
// ------------------------------------------------------------

`timescale 1ns/1ps

module ras #(
	parameter int DEPTH = bp_pkg::RAS_DEPTH
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        push_i,
	input  logic        pop_i,
	input  logic [31:2] target_i,
	output logic [31:2] target_o
);

	import bp_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [31:2]      stack_q [DEPTH];
	logic [PTR_W-1:0] top_q;
	logic [PTR_W-1:0] top_inc;
	logic [PTR_W-1:0] top_dec;

	// Pointer wrap, also for depths that are not a power of two
	assign top_inc = (top_q == PTR_W'(DEPTH - 1)) ? '0 : top_q + 1'b1;
	assign top_dec = (top_q == '0) ? PTR_W'(DEPTH - 1) : top_q - 1'b1;

	// ------------------------------------------------------------
	// Pointer
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			top_q <= '0;
		end else if (push_i) begin
			top_q <= top_inc;
		end else if (pop_i) begin
			top_q <= top_dec;
		end
	end

	// ------------------------------------------------------------
	// Entries
	// ------------------------------------------------------------

	// Empty stack returns to the boot address
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stack_q[i] <= RESET_PC[31:2];
			end
		end else if (push_i) begin
			// Overflow lands on the oldest slot
			stack_q[top_inc] <= target_i;
		end
	end

	// Top of stack is the predicted return target
	assign target_o = stack_q[top_q];

endmodule : ras

//--- hw/bpu.sv
// ------------------------------------------------------------
// Branch prediction unit
// Two-wide fetch PC, next PC from BTB, PHT and RAS
// Merges front and back update channels, one refill cycle
// after every flush
// ------------------------------------------------------------

`timescale 1ns/1ps

module bpu (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        stall_i,
	// Front update channel
	input  logic        upd_front_flush_i,
	input  logic [31:0] upd_front_target_i,
	input  logic [31:2] upd_front_pc_i,
	input  logic        upd_front_btb_we_i,
	input  logic [1:0]  upd_front_br_type_i,
	input  logic        upd_front_pht_we_i,
	input  logic        upd_front_taken_i,
	input  logic [1:0]  upd_front_cnt_i,
	input  logic [bp_pkg::LPHT_ADDR_WIDTH-1:0] upd_front_pht_index_i,
	// Back update channel
	input  logic        upd_back_flush_i,
	input  logic [31:0] upd_back_target_i,
	input  logic [31:2] upd_back_pc_i,
	input  logic        upd_back_btb_we_i,
	input  logic [1:0]  upd_back_br_type_i,
	input  logic        upd_back_pht_we_i,
	input  logic        upd_back_taken_i,
	input  logic [1:0]  upd_back_cnt_i,
	input  logic [bp_pkg::LPHT_ADDR_WIDTH-1:0] upd_back_pht_index_i,
	// Fetch side
	output logic [31:0] pc_o,
	output logic [1:0]  pc_valid_o,
	output logic        stall_o,
	// Prediction, returned later on an update channel
	output logic [31:2] pred_npc_o,
	output logic        pred_taken_o,
	output logic        pred_fsc_o,
	output logic [1:0]  pred_cnt_o,
	output logic [bp_pkg::LPHT_ADDR_WIDTH-1:0] pred_pht_index_o
);

	import bp_pkg::*;

	// ------------------------------------------------------------
	// Update merge
	// ------------------------------------------------------------

	// Back wins unless only the front flushes
	logic                       sel_back;
	logic                       upd_flush;
	logic [31:0]                upd_target;
	logic [31:2]                upd_pc;
	logic                       upd_btb_we;
	logic [1:0]                 upd_br_type;
	logic                       upd_pht_we;
	logic                       upd_taken;
	logic [1:0]                 upd_cnt;
	logic [LPHT_ADDR_WIDTH-1:0] upd_pht_index;

	assign sel_back = upd_back_flush_i | ~upd_front_flush_i;

	assign upd_flush     = sel_back ? upd_back_flush_i     : upd_front_flush_i;
	assign upd_target    = sel_back ? upd_back_target_i    : upd_front_target_i;
	assign upd_pc        = sel_back ? upd_back_pc_i        : upd_front_pc_i;
	assign upd_btb_we    = sel_back ? upd_back_btb_we_i    : upd_front_btb_we_i;
	assign upd_br_type   = sel_back ? upd_back_br_type_i   : upd_front_br_type_i;
	assign upd_pht_we    = sel_back ? upd_back_pht_we_i    : upd_front_pht_we_i;
	assign upd_taken     = sel_back ? upd_back_taken_i     : upd_front_taken_i;
	assign upd_cnt       = sel_back ? upd_back_cnt_i       : upd_front_cnt_i;
	assign upd_pht_index = sel_back ? upd_back_pht_index_i : upd_front_pht_index_i;

	// ------------------------------------------------------------
	// PC register and refill state
	// ------------------------------------------------------------

	logic        state_q;
	logic [31:2] pc_q;
	logic [31:2] npc;
	logic [31:2] ppc;
	logic        fetch_go;

	// Refill for one cycle after reset or a flush
	always_ff @(posedge clk) begin
		if (!rst_n || upd_flush) begin
			state_q <= ST_REFILL;
		end else begin
			state_q <= ST_READY;
		end
	end

	// Flush beats stall, a stall just repeats pc through npc
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= RESET_PC[31:2];
		end else if (upd_flush) begin
			pc_q <= upd_target[31:2];
		end else begin
			pc_q <= npc;
		end
	end

	// Prediction only acts outside refill and stall
	assign fetch_go = (state_q == ST_READY) && !stall_i;

	// Tables are read with npc, results line up with pc next cycle
	assign npc = fetch_go ? ppc : pc_q;

	// ------------------------------------------------------------
	// Tables
	// ------------------------------------------------------------

	logic        btb_miss;
	logic        btb_fsc;
	logic [1:0]  btb_br_type;
	logic [31:2] btb_bta;
	logic [1:0]  pht_cnt;
	logic [31:2] ras_top;

	btb #(
		.ADDR_WIDTH (BTB_ADDR_WIDTH)
	) u_btb (
		.clk       (clk),
		.rst_n     (rst_n),
		.rpc_i     (npc),
		.we_i      (upd_btb_we),
		.wpc_i     (upd_pc),
		.bta_i     (upd_target[31:2]),
		.br_type_i (upd_br_type),
		.fsc_o     (btb_fsc),
		.miss_o    (btb_miss),
		.bta_o     (btb_bta),
		.br_type_o (btb_br_type)
	);

	pht #(
		.ADDR_WIDTH (LPHT_ADDR_WIDTH)
	) u_pht (
		.clk      (clk),
		.rst_n    (rst_n),
		.we_i     (upd_pht_we),
		.taken_i  (upd_taken),
		.cnt_i    (upd_cnt),
		.rindex_i (npc[LPHT_ADDR_WIDTH+2:3]),
		.windex_i (upd_pht_index),
		.cnt_o    (pht_cnt)
	);

	// Return address is the word after the current pc
	ras #(
		.DEPTH (RAS_DEPTH)
	) u_ras (
		.clk      (clk),
		.rst_n    (rst_n),
		.push_i   (fetch_go && (btb_br_type == BR_CALL)),
		.pop_i    (fetch_go && (btb_br_type == BR_RETURN)),
		.target_i (pc_q + 30'd1),
		.target_o (ras_top)
	);

	// ------------------------------------------------------------
	// Prediction
	// ------------------------------------------------------------

	logic taken;

	// Call, return and indirect always taken
	// Type 0 follows the counter, but only on a hit
	assign taken = (btb_br_type != BR_PC_REL) || (!btb_miss && pht_cnt[CNT_TAKEN_BIT]);

	always_comb begin
		if (btb_br_type == BR_RETURN) begin
			ppc = ras_top;
		end else if (taken) begin
			ppc = btb_bta;
		end else begin
			// Sequential, next aligned fetch pair
			ppc = {pc_q[31:3] + 29'd1, 1'b0};
		end
	end

	// ------------------------------------------------------------
	// Outputs
	// ------------------------------------------------------------

	assign pc_o    = {pc_q, 2'b00};
	assign stall_o = (state_q == ST_REFILL);

	// Slot 0 dead when fetch enters at the second word
	assign pc_valid_o[0] = ~pc_q[2] & ~stall_o;
	// Slot 1 dead behind a taken branch in slot 0
	assign pc_valid_o[1] = (~(taken & btb_fsc) | pc_q[2]) & ~stall_o;

	assign pred_npc_o       = npc;
	assign pred_taken_o     = taken;
	assign pred_fsc_o       = btb_fsc;
	assign pred_cnt_o       = pht_cnt;
	assign pred_pht_index_o = pc_q[LPHT_ADDR_WIDTH+2:3];

endmodule : bpu

//--- dv/tb_clk_gen.sv
// ------------------------------------------------------------
// Testbench clock and reset
// 8 ns clock, synchronous reset held for 4 cycles
// ------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		forever #4 clk = ~clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule : tb_clk_gen

//--- dv/bpu_assertions.sv
// ------------------------------------------------------------
// Branch prediction unit checks
// Refill length, PC alignment, valids during refill
// ------------------------------------------------------------

`timescale 1ns/1ps

module bpu_assertions (
	input logic        clk,
	input logic        rst_n,
	input logic        stall_i,
	input logic        upd_flush,
	input logic        stall_o,
	input logic        pred_taken_o,
	input logic [31:0] pc_o,
	input logic [1:0]  pc_valid_o
);

	// Flush always leads to one refill cycle
	a_flush_refill: assert property (@(posedge clk) disable iff (!rst_n)
		upd_flush |=> stall_o)
		else $error("refill cycle missing after flush");

	// Refill ends after one cycle unless flushed again
	a_refill_len: assert property (@(posedge clk) disable iff (!rst_n)
		(stall_o && !upd_flush) |=> !stall_o)
		else $error("refill longer than one cycle");

	// Sequential fetch lands on an aligned fetch pair
	a_pc_align: assert property (@(posedge clk) disable iff (!rst_n)
		(!stall_o && !stall_i && !pred_taken_o && !upd_flush) |=> (pc_o[2:0] == 3'b000))
		else $error("sequential fetch not aligned to a fetch pair");

	// No slot valid in the refill cycle after a flush
	a_valid_refill: assert property (@(posedge clk) disable iff (!rst_n)
		upd_flush |=> (pc_valid_o == 2'b00))
		else $error("slot valid during refill");

endmodule : bpu_assertions

//--- dv/bpu_tb.sv
// ------------------------------------------------------------
// Branch prediction unit testbench
// Model tables, next PC reference, random stall and flush,
// PHT, branch, call/return and indirect scenarios
// ------------------------------------------------------------

`timescale 1ns/1ps

module bpu_tb;

	import bp_pkg::*;

	localparam int TOTAL_CYCLES = 600;
	localparam int BTB_N = 1 << BTB_ADDR_WIDTH;
	localparam int PHT_N = 1 << LPHT_ADDR_WIDTH;

	logic clk, rst_n, stall_i;
	logic f_flush, f_btb_we, f_pht_we, f_taken, b_flush, b_btb_we, b_pht_we, b_taken;
	logic [31:0] f_target, b_target;
	logic [31:2] f_pc, b_pc;
	logic [1:0] f_br_type, f_cnt, b_br_type, b_cnt;
	logic [LPHT_ADDR_WIDTH-1:0] f_pht_index, b_pht_index;
	logic [31:0] pc_o;
	logic [1:0] pc_valid_o, pred_cnt_o;
	logic stall_o, pred_taken_o, pred_fsc_o;
	logic [31:2] pred_npc_o;
	logic [LPHT_ADDR_WIDTH-1:0] pred_pht_index_o;

	int errors = 0;
	logic [31:0] lfsr_q = 32'h29adacde;

	tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

	bpu dut (
		.clk(clk), .rst_n(rst_n), .stall_i(stall_i),
		.upd_front_flush_i(f_flush), .upd_front_target_i(f_target),
		.upd_front_pc_i(f_pc), .upd_front_btb_we_i(f_btb_we),
		.upd_front_br_type_i(f_br_type), .upd_front_pht_we_i(f_pht_we),
		.upd_front_taken_i(f_taken), .upd_front_cnt_i(f_cnt),
		.upd_front_pht_index_i(f_pht_index),
		.upd_back_flush_i(b_flush), .upd_back_target_i(b_target),
		.upd_back_pc_i(b_pc), .upd_back_btb_we_i(b_btb_we),
		.upd_back_br_type_i(b_br_type), .upd_back_pht_we_i(b_pht_we),
		.upd_back_taken_i(b_taken), .upd_back_cnt_i(b_cnt),
		.upd_back_pht_index_i(b_pht_index),
		.pc_o(pc_o), .pc_valid_o(pc_valid_o), .stall_o(stall_o),
		.pred_npc_o(pred_npc_o), .pred_taken_o(pred_taken_o), .pred_fsc_o(pred_fsc_o),
		.pred_cnt_o(pred_cnt_o), .pred_pht_index_o(pred_pht_index_o)
	);

	bind bpu bpu_assertions u_assertions (
		.clk(clk), .rst_n(rst_n), .stall_i(stall_i), .upd_flush(upd_flush),
		.stall_o(stall_o), .pred_taken_o(pred_taken_o), .pc_o(pc_o),
		.pc_valid_o(pc_valid_o)
	);

	// ------------------------------------------------------------
	// Model state
	// ------------------------------------------------------------

	logic m_ready;
	logic [31:2] m_pc;
	logic m_bv [BTB_N];
	logic [31:9] m_btag [BTB_N];
	logic [31:2] m_bta [BTB_N];
	logic [1:0] m_btype [BTB_N];
	logic m_bfsc [BTB_N];
	logic [1:0] m_pht [PHT_N];
	logic [31:2] m_ras [RAS_DEPTH];
	int m_top;
	// Registered table reads, aligned with m_pc
	logic r_valid, r_fsc;
	logic [31:9] r_tag, r_reqtag;
	logic [31:2] r_bta;
	logic [1:0] r_type, r_cnt;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic [1:0] ref_type();
		return (r_valid && r_tag == r_reqtag) ? r_type : BR_PC_REL;
	endfunction

	// Nonzero type taken, type 0 follows counter on a hit
	function automatic logic ref_taken();
		return (ref_type() != BR_PC_REL) || (r_valid && r_tag == r_reqtag && r_cnt[1]);
	endfunction

	// Reference next PC
	function automatic logic [31:2] ref_npc(input logic stall);
		logic [31:0] seq;
		// Fall-through, bit 2 cleared then one fetch pair on
		seq = ({m_pc, 2'b00} & ~32'h4) + 32'd8;
		if (!m_ready || stall) return m_pc;
		if (ref_type() == BR_RETURN) return m_ras[m_top];
		if (ref_taken()) return r_bta;
		return seq[31:2];
	endfunction

	function automatic logic [1:0] ref_valid();
		logic v1;
		v1 = !(ref_taken() && r_fsc) || m_pc[2];
		return {v1 & m_ready, ~m_pc[2] & m_ready};
	endfunction

	task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_valid(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_cnt(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_index(input string name, input logic [LPHT_ADDR_WIDTH-1:0] got,
			input logic [LPHT_ADDR_WIDTH-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// Compare, then step the model on each rising edge
	// ------------------------------------------------------------

	always @(posedge clk) begin
		logic sb, fl, go;
		logic [1:0] typ, c;
		logic [31:2] npc, wpc;
		logic [31:0] tgt;
		int bi, pi;
		if (!rst_n) begin
			m_ready = 1'b0;
			m_pc = RESET_PC[31:2];
			m_top = 0;
			r_valid = 1'b0;
			for (int i = 0; i < BTB_N; i++) m_bv[i] = 1'b0;
			for (int i = 0; i < PHT_N; i++) m_pht[i] = CNT_WNT;
			for (int i = 0; i < RAS_DEPTH; i++) m_ras[i] = RESET_PC[31:2];
		end else begin
			check_pc("pc_o", pc_o, {m_pc, 2'b00});
			check_flag("stall_o", stall_o, !m_ready);
			check_valid("pc_valid_o", pc_valid_o, ref_valid());
			check_pc("pred_npc_o", {pred_npc_o, 2'b00}, {ref_npc(stall_i), 2'b00});
			if (m_ready) check_cnt("pred_cnt_o", pred_cnt_o, r_cnt);
			check_flag("pred_taken_o", pred_taken_o, ref_taken());
			// First slot flag only means something on a hit
			if (r_valid && r_tag == r_reqtag) check_flag("pred_fsc_o", pred_fsc_o, r_fsc);
			check_index("pred_pht_index_o", pred_pht_index_o, m_pc[10:3]);
			// Merge, back wins unless only front flushes
			sb = b_flush || !f_flush;
			fl = sb ? b_flush : f_flush;
			tgt = sb ? b_target : f_target;
			wpc = sb ? b_pc : f_pc;
			typ = ref_type();
			go = m_ready && !stall_i;
			npc = ref_npc(stall_i);
			// Table reads with npc
			bi = npc[8:3];
			pi = npc[10:3];
			r_valid = m_bv[bi];
			r_tag = m_btag[bi];
			r_reqtag = npc[31:9];
			r_bta = m_bta[bi];
			r_type = m_btype[bi];
			r_fsc = m_bfsc[bi];
			r_cnt = m_pht[pi];
			// RAS
			if (go && typ == BR_CALL) begin
				m_top = (m_top + 1) % RAS_DEPTH;
				m_ras[m_top] = m_pc + 30'd1;
			end else if (go && typ == BR_RETURN) begin
				m_top = (m_top + RAS_DEPTH - 1) % RAS_DEPTH;
			end
			// Training writes
			if (sb ? b_btb_we : f_btb_we) begin
				bi = wpc[8:3];
				m_bv[bi] = 1'b1;
				m_btag[bi] = wpc[31:9];
				m_bta[bi] = tgt[31:2];
				m_btype[bi] = sb ? b_br_type : f_br_type;
				m_bfsc[bi] = ~wpc[2];
			end
			if (sb ? b_pht_we : f_pht_we) begin
				c = sb ? b_cnt : f_cnt;
				pi = sb ? b_pht_index : f_pht_index;
				if (sb ? b_taken : f_taken) m_pht[pi] = (c == CNT_ST) ? CNT_ST : c + 2'd1;
				else m_pht[pi] = (c == CNT_SNT) ? CNT_SNT : c - 2'd1;
			end
			m_pc = fl ? tgt[31:2] : npc;
			m_ready = !fl;
		end
	end

	// ------------------------------------------------------------
	// Stimulus, on falling edges
	// ------------------------------------------------------------

	task automatic clear_inputs();
		{stall_i, f_flush, f_btb_we, f_pht_we, f_taken, b_flush, b_btb_we, b_pht_we, b_taken} = '0;
		{f_target, b_target, f_pc, b_pc} = '0;
		{f_br_type, f_cnt, b_br_type, b_cnt, f_pht_index, b_pht_index} = '0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			clear_inputs();
		end
	endtask

	// Channel 0 front, 1 back, 2 both with back winning
	task automatic flush(input int chan, input logic [31:0] tgt);
		@(negedge clk);
		clear_inputs();
		f_flush = (chan != 1);
		b_flush = (chan != 0);
		f_target = (chan == 2) ? tgt + 32'h40 : tgt;
		b_target = tgt;
	endtask

	task automatic train_btb(input logic [31:0] pc, input logic [31:0] tgt, input logic [1:0] t);
		@(negedge clk);
		clear_inputs();
		b_btb_we = 1'b1;
		b_pc = pc[31:2];
		b_target = tgt;
		b_br_type = t;
	endtask

	// Counter input taken from the model, as a later stage would return it
	task automatic train_pht(input logic [LPHT_ADDR_WIDTH-1:0] idx, input logic tk);
		@(negedge clk);
		clear_inputs();
		b_pht_we = 1'b1;
		b_pht_index = idx;
		b_cnt = m_pht[idx];
		b_taken = tk;
	endtask

	initial begin
		logic [31:0] base;
		clear_inputs();
		wait (rst_n === 1'b1);
		// Sequential fetch from reset
		idle(12);
		// Random stall with flushes on either or both channels
		for (int i = 0; i < 60; i++) begin
			if (i % 8 == 7) flush(rand_bits(2) % 3, 32'h1C00_0000 | (rand_bits(12) << 2));
			else begin
				@(negedge clk);
				clear_inputs();
				stall_i = (rand_bits(2) == 2'd0);
			end
		end
		// PHT training, read back at the trained index
		for (int i = 0; i < 12; i++) begin
			train_pht(8'h5a, rand_bits(1));
			flush(1, 32'h1C00_0000 | (32'h5a << 3));
			idle(3);
		end
		// Taken type 0 branches in slot 0 and slot 1
		train_btb(32'h1C00_1000, 32'h1C00_2040, BR_PC_REL);
		train_btb(32'h1C00_120C, 32'h1C00_3000, BR_PC_REL);
		repeat (2) train_pht(8'h00, 1'b1);
		repeat (2) train_pht(8'h41, 1'b1);
		flush(0, 32'h1C00_1000);
		idle(4);
		flush(2, 32'h1C00_1208);
		idle(4);
		// Nested calls down to RAS depth, then returns unwind
		base = 32'h1C00_8000;
		for (int k = 0; k < RAS_DEPTH; k++)
			train_btb(base + k * 32 + 4, base + (k + 1) * 32 + 4, BR_CALL);
		train_btb(base + RAS_DEPTH * 32 + 4, 32'h0, BR_RETURN);
		for (int k = 0; k < RAS_DEPTH; k++)
			train_btb(base + k * 32 + 8, 32'h0, BR_RETURN);
		flush(1, base + 4);
		idle(3 * RAS_DEPTH + 8);
		// Indirect jump taken against a not taken counter
		train_btb(32'h1C00_4010, 32'h1C00_5000, BR_INDIRECT);
		train_pht(8'h02, 1'b0);
		train_pht(8'h02, 1'b0);
		flush(0, 32'h1C00_4010);
		idle(6);
		$display("Checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog from the cycle budget of the tests
	initial begin
		#(TOTAL_CYCLES * 8 + 200);
		$display("Timeout, run did not finish within the cycle budget");
		$display("tests failed");
		$finish;
	end

endmodule : bpu_tb

//--- project.f
hw/bp_pkg.sv
hw/btb.sv
hw/pht.sv
hw/ras.sv
hw/bpu.sv
dv/tb_clk_gen.sv
dv/bpu_assertions.sv
dv/bpu_tb.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - files:
      - hw/bp_pkg.sv
      - hw/btb.sv
      - hw/pht.sv
      - hw/ras.sv
      - hw/bpu.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/bpu_assertions.sv
      - dv/bpu_tb.sv
